// File: files.f
hw/host_pkg.sv
hw/spi_rx.sv
hw/spiregs.sv
hw/kbbuf_fifo.sv
hw/sys_reset_stretch.sv
hw/host_iface_top.sv
tb/host_iface_properties.sv
tb/host_iface_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the host interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module host_iface_tb \
    --Mdir obj_dir -o host_iface_sim \
    -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/host_iface_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: tb/host_iface_tb.sv
`timescale 1ns/1ps

module host_iface_tb
    import host_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        spi_sclk;
    logic        spi_ssel_n;
    logic        spi_mosi;
    logic        kbbuf_rd;
    keys_t       keys;
    byte_t       hctrl1;
    byte_t       hctrl2;
    logic        video_mode;
    logic        sys_reset;
    byte_t       kbbuf_rdata;
    logic        kbbuf_empty;

    // Expected register state
    keys_t       exp_keys;
    byte_t       exp_hctrl1;
    byte_t       exp_hctrl2;
    logic        exp_video_mode;
    int          errors;
    int          checks;
    logic [31:0] rng_state;

    host_iface_top host_iface_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic byte_t random_byte();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[7:0];
    endfunction

    // Data byte k fills bits 63-8k down to 56-8k, the rest stays zero
    function automatic rxdata_t pack_payload(input byte_t data[$]);
        rxdata_t p;
        p = '0;
        for (int k = 0; k < 8 && k < data.size(); k++) begin
            p[63 - 8 * k -: 8] = data[k];
        end
        return p;
    endfunction

    function automatic bit regs_match();
        return keys === exp_keys && hctrl1 === exp_hctrl1 && hctrl2 === exp_hctrl2
            && video_mode === exp_video_mode;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_regs();
        check_value("keys", keys, exp_keys);
        check_value("hctrl1", 64'(hctrl1), 64'(exp_hctrl1));
        check_value("hctrl2", 64'(hctrl2), 64'(exp_hctrl2));
        check_value("video_mode", 64'(video_mode), 64'(exp_video_mode));
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-20s %0d mismatches", name, errors - errors_before);
    endtask

    ////////////////////////////////////////
    // SPI driver
    ////////////////////////////////////////

    // MSB first, mosi moves while sclk is low
    task automatic shift_byte(input byte_t b, input int nbits);
        for (int i = 7; i > 7 - nbits; i--) begin
            spi_mosi = b[i];
            repeat (4) @(negedge clk);
            spi_sclk = 1'b1;
            repeat (4) @(negedge clk);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic send_message(input byte_t cmd, input byte_t data[$], input int cmd_bits);
        repeat (8) @(negedge clk);
        spi_ssel_n = 1'b0;
        repeat (4) @(negedge clk);
        shift_byte(cmd, cmd_bits);
        foreach (data[i]) begin
            shift_byte(data[i], 8);
        end
        repeat (4) @(negedge clk);
        spi_ssel_n = 1'b1;
    endtask

    ////////////////////////////////////////
    // Waits
    ////////////////////////////////////////

    task automatic await_regs(input string what);
        int n;
        n = 0;
        while (!regs_match() && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!regs_match()) begin
            errors++;
            $display("Timeout at %0t ns: %s did not update within 20 cycles", $time, what);
        end
        check_regs();
    endtask

    // Nothing may move for the whole window
    task automatic hold_regs(input string what);
        bit moved;
        moved = 1'b0;
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            if (!regs_match() || sys_reset !== 1'b0 || kbbuf_empty !== 1'b1) begin
                moved = 1'b1;
            end
        end
        if (moved) begin
            errors++;
            $display("Outputs changed after %s at %0t ns", what, $time);
        end
        check_regs();
    endtask

    task automatic wait_empty(input logic level, input string what);
        int n;
        n = 0;
        while (kbbuf_empty !== level && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (kbbuf_empty !== level) begin
            errors++;
            $display("Timeout at %0t ns waiting for %s", $time, what);
        end
    endtask

    // Pop one entry per check, oldest first
    task automatic drain_fifo(input byte_t exp_q[$]);
        foreach (exp_q[i]) begin
            wait_empty(1'b0, "a keyboard buffer entry");
            check_value("kbbuf_rdata", 64'(kbbuf_rdata), 64'(exp_q[i]));
            kbbuf_rd = 1'b1;
            @(negedge clk);
            kbbuf_rd = 1'b0;
        end
        wait_empty(1'b1, "kbbuf_empty after the last read");
        check_value("kbbuf_empty", 64'(kbbuf_empty), 64'd1);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_values();
        int err0;
        err0 = errors;
        check_regs();
        check_value("kbbuf_empty", 64'(kbbuf_empty), 64'd1);
        check_value("sys_reset", 64'(sys_reset), 64'd0);
        report_test("reset values", err0);
    endtask

    task automatic test_keyboard_matrix();
        int    err0;
        byte_t data[$];
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            data.push_back(random_byte());
        end
        send_message(8'h10, data, 8);
        exp_keys = pack_payload(data);
        await_regs("keys from eight bytes");
        data.delete();
        for (int i = 0; i < 3; i++) begin
            data.push_back(random_byte());
        end
        send_message(8'h10, data, 8);
        exp_keys = pack_payload(data);
        await_regs("keys from three bytes");
        report_test("keyboard matrix", err0);
    endtask

    task automatic test_hctrl_vidmode();
        int    err0;
        byte_t data[$];
        err0 = errors;
        data.push_back(random_byte());
        data.push_back(random_byte());
        send_message(8'h11, data, 8);
        exp_hctrl2 = data[0];
        exp_hctrl1 = data[1];
        await_regs("hand controllers");
        data.delete();
        data.push_back(random_byte() | 8'h01);
        send_message(8'h40, data, 8);
        exp_video_mode = 1'b1;
        await_regs("video_mode set");
        data.delete();
        data.push_back(random_byte() & 8'hFE);
        send_message(8'h40, data, 8);
        exp_video_mode = 1'b0;
        await_regs("video_mode cleared");
        report_test("hctrl and video", err0);
    endtask

    task automatic test_kbbuf_order();
        int    err0;
        byte_t data[$];
        byte_t sent[$];
        err0 = errors;
        for (int i = 0; i < 16; i++) begin
            data.delete();
            data.push_back(random_byte());
            sent.push_back(data[0]);
            send_message(8'h12, data, 8);
            if (i == 0) begin
                wait_empty(1'b0, "the first keyboard buffer write");
            end
        end
        drain_fifo(sent);
        // A read on the empty buffer must not disturb the pointers
        kbbuf_rd = 1'b1;
        @(negedge clk);
        kbbuf_rd = 1'b0;
        @(negedge clk);
        check_value("kbbuf_empty", 64'(kbbuf_empty), 64'd1);
        data.delete();
        data.push_back(random_byte());
        send_message(8'h12, data, 8);
        drain_fifo(data);
        report_test("kbbuf order", err0);
    endtask

    task automatic test_kbbuf_overflow();
        int    err0;
        byte_t data[$];
        byte_t kept[$];
        err0 = errors;
        for (int i = 0; i < 18; i++) begin
            data.delete();
            data.push_back(random_byte());
            if (i < 16) begin
                kept.push_back(data[0]);
            end
            send_message(8'h12, data, 8);
        end
        // Last write lands well inside this window
        repeat (20) @(negedge clk);
        drain_fifo(kept);
        report_test("kbbuf overflow", err0);
    endtask

    task automatic test_reset_command();
        int    err0;
        int    n;
        byte_t data[$];
        err0 = errors;
        send_message(8'h01, data, 8);
        n = 0;
        while (!sys_reset && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!sys_reset) begin
            errors++;
            $display("Timeout at %0t ns waiting for sys_reset to rise", $time);
        end else begin
            n = 0;
            while (sys_reset && n < 40) begin
                @(negedge clk);
                n++;
            end
            check_value("sys_reset pulse length", 64'(n), 64'd16);
        end
        check_regs();
        report_test("reset command", err0);
    endtask

    task automatic test_ignored_input();
        int    err0;
        byte_t data[$];
        err0 = errors;
        // Reset command cut off after five bits
        // Last complete command was 01h, so a false message end would pulse sys_reset
        send_message(8'h01, data, 5);
        hold_regs("a partial command byte");
        data.push_back(8'h5A);
        data.push_back(8'hA5);
        send_message(8'h22, data, 8);
        hold_regs("unknown command 22h");
        report_test("ignored input", err0);
    endtask

    initial begin
        reset          = 1'b1;
        spi_sclk       = 1'b0;
        spi_ssel_n     = 1'b1;
        spi_mosi       = 1'b0;
        kbbuf_rd       = 1'b0;
        errors         = 0;
        checks         = 0;
        rng_state      = 32'd17378;
        exp_keys       = 64'hFFFF_FFFF_FFFF_FFFF;
        exp_hctrl1     = 8'hFF;
        exp_hctrl2     = 8'hFF;
        exp_video_mode = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset_values();
        test_keyboard_matrix();
        test_hctrl_vidmode();
        test_kbbuf_order();
        test_kbbuf_overflow();
        test_reset_command();
        test_ignored_input();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb/host_iface_properties.sv
`timescale 1ns/1ps

module host_iface_properties
    import host_pkg::*;
(
    input logic                clk,
    input logic                reset,
    input logic                kbbuf_wren,
    input logic                reset_req,
    input logic                sys_reset,
    input logic                fifo_full,
    input logic [KBBUF_AW-1:0] fifo_wr_ptr
);

    // Cycles since the last reset request, saturating
    logic [5:0] since_req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            since_req <= 6'h3F;
        end else if (reset_req) begin
            since_req <= 6'd1;
        end else if (since_req != 6'h3F) begin
            since_req <= since_req + 6'd1;
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    a_wren_one_cycle: assert property (@(posedge clk) disable iff (reset)
        kbbuf_wren |=> !kbbuf_wren)
        else $error("kbbuf_wren held high for more than one cycle");

    // High exactly for the cycles 1 to RESET_PULSE_CYCLES after a request
    a_reset_pulse: assert property (@(posedge clk) disable iff (reset)
        sys_reset == (since_req <= 6'(RESET_PULSE_CYCLES)))
        else $error("sys_reset pulse does not match the request timing");

    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        (fifo_full && kbbuf_wren) |=> $stable(fifo_wr_ptr))
        else $error("keyboard buffer accepted a write while full");

endmodule

bind host_iface_top host_iface_properties host_iface_properties_inst (
    .clk         (clk),
    .reset       (reset),
    .kbbuf_wren  (kbbuf_wren),
    .reset_req   (reset_req),
    .sys_reset   (sys_reset),
    .fifo_full   (kbbuf_fifo_inst.full),
    .fifo_wr_ptr (kbbuf_fifo_inst.wr_ptr)
);

// File: hw/host_iface_top.sv
`timescale 1ns/1ps

module host_iface_top
    import host_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // SPI pins from the microcontroller, asynchronous
    input  logic  spi_sclk,
    input  logic  spi_ssel_n,
    input  logic  spi_mosi,

    // Computer side
    input  logic  kbbuf_rd,
    output keys_t keys,
    output byte_t hctrl1,
    output byte_t hctrl2,
    output logic  video_mode,
    output logic  sys_reset,
    output byte_t kbbuf_rdata,
    output logic  kbbuf_empty
);

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////

    byte_t   spi_cmd;
    rxdata_t spi_rxdata;
    logic    spi_msg_end;
    logic    reset_req;
    byte_t   kbbuf_data;
    logic    kbbuf_wren;

    spi_rx spi_rx_inst (
        .clk         (clk),
        .reset       (reset),
        .spi_sclk    (spi_sclk),
        .spi_ssel_n  (spi_ssel_n),
        .spi_mosi    (spi_mosi),
        .spi_cmd     (spi_cmd),
        .spi_rxdata  (spi_rxdata),
        .spi_msg_end (spi_msg_end)
    );

    spiregs spiregs_inst (
        .clk         (clk),
        .reset       (reset),
        .spi_msg_end (spi_msg_end),
        .spi_cmd     (spi_cmd),
        .spi_rxdata  (spi_rxdata),
        .reset_req   (reset_req),
        .keys        (keys),
        .hctrl1      (hctrl1),
        .hctrl2      (hctrl2),
        .kbbuf_data  (kbbuf_data),
        .kbbuf_wren  (kbbuf_wren),
        .video_mode  (video_mode)
    );

    kbbuf_fifo kbbuf_fifo_inst (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (kbbuf_wren),
        .wr_data (kbbuf_data),
        .rd_en   (kbbuf_rd),
        .rd_data (kbbuf_rdata),
        .empty   (kbbuf_empty)
    );

    sys_reset_stretch sys_reset_stretch_inst (
        .clk       (clk),
        .reset     (reset),
        .reset_req (reset_req),
        .sys_reset (sys_reset)
    );

endmodule

// File: hw/sys_reset_stretch.sv
`timescale 1ns/1ps

module sys_reset_stretch
    import host_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic reset_req,
    output logic sys_reset
);

    logic [RESET_CNT_W-1:0] cnt;

    // A request during the pulse reloads the full length
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if (reset_req) begin
            cnt <= RESET_CNT_W'(RESET_PULSE_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // High for exactly RESET_PULSE_CYCLES cycles after the last request
    assign sys_reset = (cnt != '0);

endmodule

// File: hw/kbbuf_fifo.sv
`timescale 1ns/1ps

module kbbuf_fifo
    import host_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  rd_en,
    output byte_t rd_data,
    output logic  empty
);

    byte_t               mem [KBBUF_DEPTH];
    logic [KBBUF_AW-1:0] wr_ptr;
    logic [KBBUF_AW-1:0] rd_ptr;
    logic [KBBUF_AW:0]   count;
    logic                full;
    logic                push;
    logic                pop;

    assign full  = (count == (KBBUF_AW + 1)'(KBBUF_DEPTH));
    assign empty = (count == '0);

    // Writes into a full buffer and reads from an empty one are dropped
    assign push = wr_en && !full;
    assign pop  = rd_en && !empty;

    ////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Oldest entry, valid while not empty
    assign rd_data = mem[rd_ptr];

endmodule

// File: hw/spiregs.sv
`timescale 1ns/1ps

module spiregs
    import host_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  logic    spi_msg_end,
    input  byte_t   spi_cmd,
    input  rxdata_t spi_rxdata,

    output logic    reset_req,
    output keys_t   keys,
    output byte_t   hctrl1,
    output byte_t   hctrl2,

    output byte_t   kbbuf_data,
    output logic    kbbuf_wren,

    output logic    video_mode
);

    ////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////

    logic hit_reset;
    logic hit_keys;
    logic hit_hctrl;
    logic hit_kbbuf;
    logic hit_vidmode;

    // Unknown codes match nothing and leave every register alone
    assign hit_reset   = spi_msg_end && (spi_cmd == CMD_RESET);
    assign hit_keys    = spi_msg_end && (spi_cmd == CMD_SET_KEYB_MATRIX);
    assign hit_hctrl   = spi_msg_end && (spi_cmd == CMD_SET_HCTRL);
    assign hit_kbbuf   = spi_msg_end && (spi_cmd == CMD_WRITE_KBBUF);
    assign hit_vidmode = spi_msg_end && (spi_cmd == CMD_SET_VIDMODE);

    // 01h system reset request, one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reset_req <= 1'b0;
        end else begin
            reset_req <= hit_reset;
        end
    end

    // 10h keyboard matrix, whole payload
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            keys <= KEYS_RESET_VALUE;
        end else if (hit_keys) begin
            keys <= spi_rxdata;
        end
    end

    // 11h hand controllers, first byte is controller 2
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hctrl2 <= HCTRL_RESET_VALUE;
            hctrl1 <= HCTRL_RESET_VALUE;
        end else if (hit_hctrl) begin
            hctrl2 <= spi_rxdata[63:56];
            hctrl1 <= spi_rxdata[55:48];
        end
    end

    // 12h keyboard buffer write strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            kbbuf_wren <= 1'b0;
        end else begin
            kbbuf_wren <= hit_kbbuf;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_kbbuf) begin
            kbbuf_data <= spi_rxdata[63:56];
        end
    end

    // 40h video mode from bit 0 of the first data byte
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            video_mode <= 1'b0;
        end else if (hit_vidmode) begin
            video_mode <= spi_rxdata[56];
        end
    end

endmodule

// File: hw/spi_rx.sv
`timescale 1ns/1ps

module spi_rx
    import host_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    spi_sclk,
    input  logic    spi_ssel_n,
    input  logic    spi_mosi,
    output byte_t   spi_cmd,
    output rxdata_t spi_rxdata,
    output logic    spi_msg_end
);

    ////////////////////////////////////////
    // Pin synchronizers and edge detect
    ////////////////////////////////////////

    logic [1:0] sclk_sync;
    logic [1:0] ssel_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       ssel_prev;
    logic       sclk_rise;
    logic       ssel_fall;
    logic       ssel_rise;
    logic       mosi_bit;

    // Select idles high so no false start comes out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sclk_sync <= 2'b00;
            ssel_sync <= 2'b11;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
            ssel_prev <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            ssel_sync <= {ssel_sync[0], spi_ssel_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_prev <= sclk_sync[1];
            ssel_prev <= ssel_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign ssel_fall = ~ssel_sync[1] & ssel_prev;
    assign ssel_rise = ssel_sync[1] & ~ssel_prev;
    assign mosi_bit  = mosi_sync[1];

    ////////////////////////////////////////
    // Message framing FSM
    ////////////////////////////////////////

    rx_state_t  state;
    logic [2:0] bit_cnt;
    logic [3:0] byte_idx;
    logic       bit_strobe;
    logic       byte_done;
    byte_t      shift_q;
    byte_t      next_byte;

    // Select edges take priority over clock edges in the same cycle
    assign bit_strobe = sclk_rise && !ssel_fall && !ssel_rise && (state != RX_IDLE);
    assign byte_done  = bit_strobe && (bit_cnt == 3'd7);
    assign next_byte  = {shift_q[6:0], mosi_bit};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= RX_IDLE;
            bit_cnt     <= 3'd0;
            byte_idx    <= 4'd0;
            spi_msg_end <= 1'b0;
        end else begin
            spi_msg_end <= 1'b0;
            if (ssel_fall) begin
                state    <= RX_CMD;
                bit_cnt  <= 3'd0;
                byte_idx <= 4'd0;
            end else if (ssel_rise) begin
                // Only a complete command byte makes a message
                spi_msg_end <= (state == RX_DATA);
                state       <= RX_IDLE;
            end else if (bit_strobe) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (byte_done) begin
                    case (state)
                        RX_CMD:  state <= RX_DATA;
                        RX_DATA: if (!byte_idx[3]) byte_idx <= byte_idx + 4'd1;
                        default: state <= RX_IDLE;
                    endcase
                end
            end
        end
    end

    ////////////////////////////////////////
    // Byte assembly
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bit_strobe) begin
            shift_q <= next_byte;
        end
        if (byte_done && state == RX_CMD) begin
            spi_cmd <= next_byte;
        end
        // Data byte k lands at bits 63-8k down to 56-8k, extras dropped
        if (ssel_fall) begin
            spi_rxdata <= '0;
        end else if (byte_done && state == RX_DATA && !byte_idx[3]) begin
            spi_rxdata[{~byte_idx[2:0], 3'b000} +: 8] <= next_byte;
        end
    end

endmodule

// File: hw/host_pkg.sv
package host_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Command and data bytes on the SPI link
    typedef logic [7:0] byte_t;

    // Message payload, first data byte in the top bits
    typedef logic [63:0] rxdata_t;

    // Keyboard matrix, 0 means pressed
    typedef logic [63:0] keys_t;

    ////////////////////////////////////////
    // Command codes
    ////////////////////////////////////////

    localparam byte_t CMD_RESET           = 8'h01;
    localparam byte_t CMD_SET_KEYB_MATRIX = 8'h10;
    localparam byte_t CMD_SET_HCTRL       = 8'h11;
    localparam byte_t CMD_WRITE_KBBUF     = 8'h12;
    localparam byte_t CMD_SET_VIDMODE     = 8'h40;

    // Register values after reset
    localparam keys_t KEYS_RESET_VALUE  = '1;
    localparam byte_t HCTRL_RESET_VALUE = 8'hFF;

    // Keyboard buffer geometry
    localparam int KBBUF_DEPTH = 16;
    localparam int KBBUF_AW    = 4;

    // System reset pulse length in clk cycles
    localparam int RESET_PULSE_CYCLES = 16;
    localparam int RESET_CNT_W        = $clog2(RESET_PULSE_CYCLES + 1);

    // SPI receiver states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_CMD,
        RX_DATA
    } rx_state_t;

endpackage
